// File: sources.f
dcache_pkg.sv
dcache_ram.sv
dcache_way.sv
dcache_ctrl.sv
dcache_resp.sv
dcache_top.sv
tb_clkgen.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f sources.f

out=$(./obj_dir/Vtb_dcache)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb_dcache.sv
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    DRIVE_DLY   = 2;
    localparam addr_t WIN_BASE    = 32'h0000_4000;
    localparam int    N_RAND      = 400;
    localparam int    N_REPEAT    = 20;
    localparam int    N_LONG      = 200;
    localparam int    N_WORDS     = 64;
    localparam int    MISS_CYCLES = 80;  // write-back plus refill at the longest ready delay
    localparam int    N_REQ       = N_RAND + 2 * N_REPEAT + N_LONG + N_WORDS;
    localparam int    TIMEOUT     = (N_REQ + 20) * MISS_CYCLES * CLK_PERIOD;

    logic  clk;
    logic  rstn;
    logic  i_req_valid;
    logic  i_req_write;
    addr_t i_req_addr;
    word_t i_req_wdata;
    size_e i_req_size;
    logic  i_req_signed;
    logic  o_req_ready;
    logic  o_resp_valid;
    word_t o_resp_rdata;
    logic  o_mem_rd_valid;
    logic  i_mem_rd_ready;
    addr_t o_mem_rd_addr;
    line_t i_mem_rd_data;
    logic  o_mem_wr_valid;
    logic  i_mem_wr_ready;
    addr_t o_mem_wr_addr;
    line_t o_mem_wr_data;

    logic [7:0]  ref_mem [256];    // architectural bytes of the window
    logic [7:0]  mem_model [256];  // what the backing memory holds
    logic [31:0] lfsr_state  = 32'h419f_630f;
    logic        long_delays = 1'b0;
    int          err_count   = 0;
    int          check_count = 0;
    int          accept_count = 0;
    int          resp_count  = 0;

    tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_tb_clkgen (.clk(clk), .rstn(rstn));

    dcache_top u_dcache_top (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .i_req_size     (i_req_size),
        .i_req_signed   (i_req_signed),
        .o_req_ready    (o_req_ready),
        .o_resp_valid   (o_resp_valid),
        .o_resp_rdata   (o_resp_rdata),
        .o_mem_rd_valid (o_mem_rd_valid),
        .i_mem_rd_ready (i_mem_rd_ready),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_data  (i_mem_rd_data),
        .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // window is 4 tags x sets 0..3, so every set sees evictions
    function automatic addr_t win_addr(input int i);
        addr_t a;
        a = WIN_BASE;
        a[9:8] = i[7:6];
        a[5:4] = i[5:4];
        a[3:0] = i[3:0];
        return a;
    endfunction

    function automatic int win_idx(input addr_t a);
        return int'({a[9:8], a[5:4], a[3:0]});
    endfunction

    function automatic logic in_window(input addr_t a);
        return (a[31:10] == WIN_BASE[31:10]) && (a[7:6] == 2'b00);
    endfunction

    function automatic logic [7:0] fill_byte(input addr_t a);
        return (a[7:0] * 8'd37) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic line_t read_line(input logic from_ref, input addr_t a);
        line_t l;
        int    base;
        base = win_idx(a) & ~15;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = from_ref ? ref_mem[base + b] : mem_model[base + b];
        end
        return l;
    endfunction

    // little-endian, extension by the signed flag
    function automatic word_t expected_load(input addr_t a, input size_e size, input logic sgn);
        int i;
        i = win_idx(a);
        case (size)
            SIZE_BYTE: return {{24{sgn & ref_mem[i][7]}}, ref_mem[i]};
            SIZE_HALF: return {{16{sgn & ref_mem[i+1][7]}}, ref_mem[i+1], ref_mem[i]};
            default:   return {ref_mem[i+3], ref_mem[i+2], ref_mem[i+1], ref_mem[i]};
        endcase
    endfunction

    task automatic store_ref(input addr_t a, input word_t d, input size_e size);
        int n;
        n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            ref_mem[win_idx(a) + b] = d[b*8 +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-14s %0d errors", name, err_count - err_before);
    endtask

    task automatic do_request(input logic wr, input addr_t a, input word_t d, input size_e size,
                              input logic sgn, output int latency, output logic saw_rd);
        @(posedge clk);
        #(DRIVE_DLY);
        i_req_valid  = 1'b1;
        i_req_write  = wr;
        i_req_addr   = a;
        i_req_wdata  = d;
        i_req_size   = size;
        i_req_signed = sgn;
        do begin
            @(negedge clk);
        end while (!o_req_ready);
        @(posedge clk);  // accepting edge
        #(DRIVE_DLY);
        i_req_valid = 1'b0;
        accept_count++;
        latency = 0;
        saw_rd  = 1'b0;
        do begin
            @(negedge clk);
            latency++;
            saw_rd = saw_rd | o_mem_rd_valid;
        end while (!o_resp_valid);
        if (wr) begin
            store_ref(a, d, size);
        end else begin
            check_value("o_resp_rdata", o_resp_rdata, expected_load(a, size, sgn));
        end
    endtask

    task automatic random_request();
        logic        wr;
        logic [31:0] sz;
        size_e       size;
        addr_t       a;
        word_t       d;
        logic        sgn;
        int          lat;
        logic        rd;
        wr   = rand_bits(1) != 0;
        sz   = rand_bits(2);
        size = (sz == 0) ? SIZE_BYTE : (sz == 1) ? SIZE_HALF : SIZE_WORD;
        a    = win_addr(int'(rand_bits(8)));
        if (size == SIZE_HALF) a[0] = 1'b0;
        if (size == SIZE_WORD) a[1:0] = 2'b00;
        d    = rand_bits(32);
        sgn  = rand_bits(1) != 0;
        do_request(wr, a, d, size, sgn, lat, rd);
    endtask

    always @(negedge clk) begin
        if (rstn && o_resp_valid) resp_count++;
    end

    initial begin : mem_read_model
        int    delay;
        addr_t a;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_rd_valid) begin
                a = o_mem_rd_addr;
                check_value("o_mem_rd_addr offset", a[3:0], 0);
                check_value("o_mem_rd_addr in window", in_window(a), 1);
                delay = int'(rand_bits(long_delays ? 5 : 2));
                repeat (delay + 1) @(posedge clk);
                #(DRIVE_DLY);
                i_mem_rd_data  = read_line(1'b0, a);
                i_mem_rd_ready = 1'b1;
                @(posedge clk);  // line taken here
                #(DRIVE_DLY);
                i_mem_rd_ready = 1'b0;
            end
        end
    end

    initial begin : mem_write_model
        int    delay;
        addr_t a;
        line_t l;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_wr_valid) begin
                a = o_mem_wr_addr;
                l = o_mem_wr_data;
                check_value("o_mem_wr_addr offset", a[3:0], 0);
                check_value("o_mem_wr_addr in window", in_window(a), 1);
                check_value("o_mem_wr_data", l, read_line(1'b1, a));
                delay = int'(rand_bits(long_delays ? 5 : 2));
                repeat (delay + 1) @(posedge clk);
                #(DRIVE_DLY);
                i_mem_wr_ready = 1'b1;
                @(posedge clk);
                for (int b = 0; b < LINE_BYTES; b++) begin
                    mem_model[win_idx(a) + b] = l[b*8 +: 8];
                end
                #(DRIVE_DLY);
                i_mem_wr_ready = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("timeout: the cache stopped answering after %0d requests", accept_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        int    err_before;
        int    lat;
        logic  rd;
        addr_t a;
        i_req_valid    = 1'b0;
        i_req_write    = 1'b0;
        i_req_addr     = '0;
        i_req_wdata    = '0;
        i_req_size     = SIZE_WORD;
        i_req_signed   = 1'b0;
        i_mem_rd_ready = 1'b0;
        i_mem_rd_data  = '0;
        i_mem_wr_ready = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]   = fill_byte(win_addr(i));
            mem_model[i] = fill_byte(win_addr(i));
        end

        err_before = err_count;
        @(posedge rstn);
        @(negedge clk);
        check_value("o_req_ready", o_req_ready, 1);
        check_value("o_resp_valid", o_resp_valid, 0);
        check_value("o_mem_rd_valid", o_mem_rd_valid, 0);
        check_value("o_mem_wr_valid", o_mem_wr_valid, 0);
        report_test("reset_values", err_before);

        err_before = err_count;
        for (int n = 0; n < N_RAND; n++) random_request();
        report_test("random_short", err_before);

        err_before = err_count;
        for (int n = 0; n < N_REPEAT; n++) begin
            a = win_addr(int'(rand_bits(8)));
            a[1:0] = 2'b00;
            do_request(1'b0, a, '0, SIZE_WORD, 1'b0, lat, rd);
            do_request(1'b0, a, '0, SIZE_WORD, 1'b0, lat, rd);  // must hit now
            check_value("hit latency", lat, 1);
            check_value("o_mem_rd_valid on hit", rd, 0);
        end
        report_test("repeat_hit", err_before);

        err_before = err_count;
        long_delays = 1'b1;
        for (int n = 0; n < N_LONG; n++) random_request();
        report_test("random_long", err_before);

        err_before = err_count;
        for (int i = 0; i < N_WORDS; i++) begin
            do_request(1'b0, win_addr(i * 4), '0, SIZE_WORD, 1'b0, lat, rd);
        end
        @(posedge clk);
        check_value("response count", resp_count, accept_count);
        report_test("readback", err_before);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10,
    parameter int RELEASE_DLY  = 2    // reset leaves a little after the edge
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_DLY) rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic               clk,
    input  logic               rstn,
    // pipeline
    input  logic               i_req_valid,
    input  logic               i_req_write,
    input  dcache_pkg::addr_t  i_req_addr,
    input  dcache_pkg::word_t  i_req_wdata,
    input  dcache_pkg::size_e  i_req_size,
    input  logic               i_req_signed,
    output logic               o_req_ready,
    output logic               o_resp_valid,
    output dcache_pkg::word_t  o_resp_rdata,
    // memory
    output logic               o_mem_rd_valid,
    input  logic               i_mem_rd_ready,
    output dcache_pkg::addr_t  o_mem_rd_addr,
    input  dcache_pkg::line_t  i_mem_rd_data,
    output logic               o_mem_wr_valid,
    input  logic               i_mem_wr_ready,
    output dcache_pkg::addr_t  o_mem_wr_addr,
    output dcache_pkg::line_t  o_mem_wr_data
);

    import dcache_pkg::*;

    index_t     rd_index;
    index_t     wr_index;
    tag_t       lookup_tag;
    way_vec_t   line_we;
    line_strb_t line_strb;
    line_t      line_wdata;
    way_vec_t   tag_we;
    way_vec_t   set_dirty;
    way_vec_t   clr_dirty;
    way_vec_t   way_hit;
    way_vec_t   way_dirty;
    tag_t       way_tag [NUM_WAYS];
    line_t      way_line [NUM_WAYS];
    logic [1:0] word_off;
    logic [1:0] byte_off;
    size_e      buf_size;
    logic       buf_signed;

    dcache_ctrl u_dcache_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .i_req_size     (i_req_size),
        .i_req_signed   (i_req_signed),
        .o_req_ready    (o_req_ready),
        .o_resp_valid   (o_resp_valid),
        .o_rd_index     (rd_index),
        .o_wr_index     (wr_index),
        .o_lookup_tag   (lookup_tag),
        .o_line_we      (line_we),
        .o_line_strb    (line_strb),
        .o_line_wdata   (line_wdata),
        .o_tag_we       (tag_we),
        .o_set_dirty    (set_dirty),
        .o_clr_dirty    (clr_dirty),
        .i_hit          (way_hit),
        .i_dirty        (way_dirty),
        .i_tag          (way_tag),
        .i_line         (way_line),
        .o_word_off     (word_off),
        .o_byte_off     (byte_off),
        .o_size         (buf_size),
        .o_signed       (buf_signed),
        .o_mem_rd_valid (o_mem_rd_valid),
        .i_mem_rd_ready (i_mem_rd_ready),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_data  (i_mem_rd_data),
        .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_dcache_way (
            .clk          (clk),
            .rstn         (rstn),
            .i_rd_index   (rd_index),
            .i_wr_index   (wr_index),
            .i_lookup_tag (lookup_tag),
            .i_line_we    (line_we[w]),
            .i_line_strb  (line_strb),
            .i_line_wdata (line_wdata),
            .i_tag_we     (tag_we[w]),
            .i_wr_tag     (lookup_tag),  // refill installs the request tag
            .i_set_dirty  (set_dirty[w]),
            .i_clr_dirty  (clr_dirty[w]),
            .o_hit        (way_hit[w]),
            .o_dirty      (way_dirty[w]),
            .o_tag        (way_tag[w]),
            .o_line       (way_line[w])
        );
    end

    dcache_resp u_dcache_resp (
        .i_hit      (way_hit),
        .i_line     (way_line),
        .i_word_off (word_off),
        .i_byte_off (byte_off),
        .i_size     (buf_size),
        .i_signed   (buf_signed),
        .o_rdata    (o_resp_rdata)
    );

endmodule

`default_nettype wire

// File: dcache_resp.sv
`default_nettype none

module dcache_resp (
    input  dcache_pkg::way_vec_t i_hit,
    input  dcache_pkg::line_t    i_line [dcache_pkg::NUM_WAYS],
    input  logic [1:0]           i_word_off,
    input  logic [1:0]           i_byte_off,
    input  dcache_pkg::size_e    i_size,
    input  logic                 i_signed,
    output dcache_pkg::word_t    o_rdata
);

    import dcache_pkg::*;

    line_t       sel_line;
    word_t       sel_word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // at most one way hits
    always_comb begin
        sel_line = i_line[0];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_hit[w]) sel_line = i_line[w];
        end
    end

    assign sel_word = sel_line[i_word_off * WORD_W +: WORD_W];
    assign sel_byte = sel_word[i_byte_off * 8 +: 8];
    assign sel_half = sel_word[i_byte_off[1] * 16 +: 16];  // half-word aligned

    always_comb begin
        case (i_size)
            SIZE_BYTE: o_rdata = {{24{i_signed & sel_byte[7]}}, sel_byte};
            SIZE_HALF: o_rdata = {{16{i_signed & sel_half[15]}}, sel_half};
            default:   o_rdata = sel_word;
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    // pipeline request
    input  logic                   i_req_valid,
    input  logic                   i_req_write,
    input  dcache_pkg::addr_t      i_req_addr,
    input  dcache_pkg::word_t      i_req_wdata,
    input  dcache_pkg::size_e      i_req_size,
    input  logic                   i_req_signed,
    output logic                   o_req_ready,
    output logic                   o_resp_valid,
    // way control
    output dcache_pkg::index_t     o_rd_index,
    output dcache_pkg::index_t     o_wr_index,
    output dcache_pkg::tag_t       o_lookup_tag,
    output dcache_pkg::way_vec_t   o_line_we,
    output dcache_pkg::line_strb_t o_line_strb,
    output dcache_pkg::line_t      o_line_wdata,
    output dcache_pkg::way_vec_t   o_tag_we,
    output dcache_pkg::way_vec_t   o_set_dirty,
    output dcache_pkg::way_vec_t   o_clr_dirty,
    input  dcache_pkg::way_vec_t   i_hit,
    input  dcache_pkg::way_vec_t   i_dirty,
    input  dcache_pkg::tag_t       i_tag [dcache_pkg::NUM_WAYS],
    input  dcache_pkg::line_t      i_line [dcache_pkg::NUM_WAYS],
    // buffered request for load alignment
    output logic [1:0]             o_word_off,
    output logic [1:0]             o_byte_off,
    output dcache_pkg::size_e      o_size,
    output logic                   o_signed,
    // memory side
    output logic                   o_mem_rd_valid,
    input  logic                   i_mem_rd_ready,
    output dcache_pkg::addr_t      o_mem_rd_addr,
    input  dcache_pkg::line_t      i_mem_rd_data,
    output logic                   o_mem_wr_valid,
    input  logic                   i_mem_wr_ready,
    output dcache_pkg::addr_t      o_mem_wr_addr,
    output dcache_pkg::line_t      o_mem_wr_data
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL
    } state_e;

    state_e state;
    state_e state_next;

    // request buffer
    logic   req_write;
    addr_t  req_addr;
    word_t  req_wdata;
    size_e  req_size;
    logic   req_signed;
    index_t req_index;
    tag_t   req_tag;

    logic [SETS-1:0]   lru;          // way to evict next, per set
    logic              lru_way;
    logic              victim;
    way_vec_t          victim_oh;
    addr_t             wb_addr;
    line_t             wb_line;

    logic              accept;
    logic              lookup_hit;
    logic              store_hit;
    logic              rd_done;
    logic [WORD_W/8-1:0] word_strb;
    word_t             store_word;

    assign accept     = i_req_valid && o_req_ready;
    assign req_index  = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign lookup_hit = (state == S_LOOKUP) && (|i_hit);
    assign store_hit  = lookup_hit && req_write;
    assign rd_done    = (state == S_REFILL) && i_mem_rd_ready;
    assign lru_way    = lru[req_index];
    assign victim_oh  = way_vec_t'(1) << victim;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_write  <= i_req_write;
            req_addr   <= i_req_addr;
            req_wdata  <= i_req_wdata;
            req_size   <= i_req_size;
            req_signed <= i_req_signed;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:      if (i_req_valid) state_next = S_LOOKUP;
            S_LOOKUP: begin
                if (|i_hit) begin
                    state_next = S_IDLE;
                end else if (i_dirty[lru_way]) begin
                    state_next = S_WRITEBACK;
                end else begin
                    state_next = S_REFILL;
                end
            end
            S_WRITEBACK: if (i_mem_wr_ready) state_next = S_REFILL;
            S_REFILL:    if (i_mem_rd_ready) state_next = S_LOOKUP;  // rerun, now hits
            default:     state_next = S_IDLE;
        endcase
    end

    // victim and write-back buffer, captured on the missing lookup
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP && !(|i_hit)) begin
            victim  <= lru_way;
            wb_addr <= {i_tag[lru_way], req_index, {OFFSET_W{1'b0}}};
            wb_line <= i_line[lru_way];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (lookup_hit) begin
            lru[req_index] <= ~i_hit[1];  // other way becomes LRU
        end else if (rd_done) begin
            lru[req_index] <= ~victim;
        end
    end

    // store strobes and data placed at every word slot
    always_comb begin
        case (req_size)
            SIZE_BYTE: begin
                word_strb  = 4'b0001 << req_addr[1:0];
                store_word = {4{req_wdata[7:0]}};
            end
            SIZE_HALF: begin
                word_strb  = 4'b0011 << req_addr[1:0];
                store_word = {2{req_wdata[15:0]}};
            end
            default: begin
                word_strb  = 4'b1111;
                store_word = req_wdata;
            end
        endcase
    end

    assign o_req_ready  = (state == S_IDLE);
    assign o_resp_valid = lookup_hit;

    // the RAMs see the incoming index so a hit answers one cycle after accept
    assign o_rd_index   = (state == S_IDLE) ? i_req_addr[OFFSET_W +: INDEX_W] : req_index;
    assign o_wr_index   = req_index;
    assign o_lookup_tag = req_tag;

    assign o_line_we    = store_hit ? i_hit : (rd_done ? victim_oh : '0);
    assign o_tag_we     = rd_done ? victim_oh : '0;
    assign o_set_dirty  = store_hit ? i_hit : '0;
    assign o_clr_dirty  = rd_done ? victim_oh : '0;
    assign o_line_strb  = rd_done ? '1
                        : line_strb_t'(word_strb) << {req_addr[OFFSET_W-1:2], 2'b00};
    assign o_line_wdata = rd_done ? i_mem_rd_data : {WORDS_PER_LINE{store_word}};

    assign o_word_off   = req_addr[3:2];
    assign o_byte_off   = req_addr[1:0];
    assign o_size       = req_size;
    assign o_signed     = req_signed;

    assign o_mem_rd_valid = (state == S_REFILL);
    assign o_mem_rd_addr  = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_wr_valid = (state == S_WRITEBACK);
    assign o_mem_wr_addr  = wb_addr;
    assign o_mem_wr_data  = wb_line;

    a_req_aligned: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> ((i_req_size == SIZE_HALF) -> !i_req_addr[0])
               && ((i_req_size == SIZE_WORD) -> (i_req_addr[1:0] == 2'b00)));

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        (state == S_LOOKUP) |-> !(&i_hit));

    a_rd_stable: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rd_valid && !i_mem_rd_ready |=> o_mem_rd_valid && $stable(o_mem_rd_addr));

    a_wr_stable: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_valid && !i_mem_wr_ready |=> o_mem_wr_valid && $stable(o_mem_wr_addr)
            && $stable(o_mem_wr_data));

endmodule

`default_nettype wire

// File: dcache_way.sv
`default_nettype none

module dcache_way (
    input  logic                   clk,
    input  logic                   rstn,
    input  dcache_pkg::index_t     i_rd_index,
    input  dcache_pkg::index_t     i_wr_index,
    input  dcache_pkg::tag_t       i_lookup_tag,
    input  logic                   i_line_we,
    input  dcache_pkg::line_strb_t i_line_strb,
    input  dcache_pkg::line_t      i_line_wdata,
    input  logic                   i_tag_we,
    input  dcache_pkg::tag_t       i_wr_tag,
    input  logic                   i_set_dirty,
    input  logic                   i_clr_dirty,
    output logic                   o_hit,
    output logic                   o_dirty,
    output dcache_pkg::tag_t       o_tag,
    output dcache_pkg::line_t      o_line
);

    import dcache_pkg::*;

    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;
    logic            valid_q;
    logic            dirty_q;
    logic            valid_next;
    logic            dirty_next;
    logic            same_set;

    dcache_ram #(
        .payload_t (tag_t),
        .DEPTH     (SETS)
    ) u_tag_ram (
        .clk       (clk),
        .i_rd_addr (i_rd_index),
        .i_wr_addr (i_wr_index),
        .i_we      (i_tag_we),
        .i_byte_we ('1),            // tags are always written whole
        .i_wdata   (i_wr_tag),
        .o_rdata   (o_tag)
    );

    dcache_ram #(
        .payload_t (line_t),
        .DEPTH     (SETS)
    ) u_data_ram (
        .clk       (clk),
        .i_rd_addr (i_rd_index),
        .i_wr_addr (i_wr_index),
        .i_we      (i_line_we),
        .i_byte_we (i_line_strb),
        .i_wdata   (i_line_wdata),
        .o_rdata   (o_line)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (i_tag_we) valid_bits[i_wr_index] <= 1'b1;  // refill validates the set
            if (i_set_dirty) begin
                dirty_bits[i_wr_index] <= 1'b1;
            end else if (i_clr_dirty) begin
                dirty_bits[i_wr_index] <= 1'b0;
            end
        end
    end

    // state bits follow the RAM read timing, same write-first bypass
    assign same_set = (i_wr_index == i_rd_index);

    always_comb begin
        valid_next = valid_bits[i_rd_index] | (i_tag_we & same_set);
        dirty_next = dirty_bits[i_rd_index];
        if (same_set && i_set_dirty) begin
            dirty_next = 1'b1;
        end else if (same_set && i_clr_dirty) begin
            dirty_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            valid_q <= valid_next;
            dirty_q <= dirty_next;
        end
    end

    assign o_hit   = valid_q && (o_tag == i_lookup_tag);
    assign o_dirty = valid_q && dirty_q;  // only a valid line needs write-back

    a_dirty_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(i_set_dirty && i_clr_dirty));

endmodule

`default_nettype wire

// File: dcache_ram.sv
`default_nettype none

module dcache_ram #(
    parameter type payload_t = dcache_pkg::line_t,
    parameter int  DEPTH     = dcache_pkg::SETS
) (
    input  logic                           clk,
    input  dcache_pkg::index_t             i_rd_addr,
    input  dcache_pkg::index_t             i_wr_addr,
    input  logic                           i_we,
    input  logic [$bits(payload_t)/8-1:0]  i_byte_we,
    input  payload_t                       i_wdata,
    output payload_t                       o_rdata
);

    payload_t mem [DEPTH];
    payload_t rd_next;

    // write-first: bytes written this cycle show up on the read port
    always_comb begin
        rd_next = mem[i_rd_addr];
        for (int b = 0; b < $bits(payload_t) / 8; b++) begin
            if (i_we && i_byte_we[b] && (i_wr_addr == i_rd_addr)) begin
                rd_next[b*8 +: 8] = i_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        o_rdata <= rd_next;  // registered read
        if (i_we) begin
            for (int b = 0; b < $bits(payload_t) / 8; b++) begin
                if (i_byte_we[b]) begin
                    mem[i_wr_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;   // 128
    localparam int LINE_BYTES     = LINE_W / 8;                // 16
    localparam int OFFSET_W       = $clog2(LINE_BYTES);        // byte offset in a line
    localparam int INDEX_W        = 4;
    localparam int SETS           = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;  // 24
    localparam int NUM_WAYS       = 2;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [NUM_WAYS-1:0]   way_vec_t;  // one-hot or hit vector

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

endpackage

`default_nettype wire
